//--- csr_stim.txt
# name kind addr wdata expect, numbers in hex
# kinds rd rw set clr rnd(wdata is mask) exr exw cmd trp(wdata pc, expect cause) cyc
hartid     rd  f14 00000000 00000003
archid     rd  f12 00000000 00000021
misa       rd  301 00000000 40000100
mtvec_boot rd  305 00000000 00008000
wbase_rw   rw  7c0 12345678 12345678
wstr_set   set 7c3 0000f0f0 0000f0f0
wbase_clr  clr 7c0 000000ff 12345600
mepc_rw    rw  341 80001003 80001002
mepc_set   set 341 00000005 80001006
rand_prec  rnd 7db ffffffff 00000000
rand_olen  rnd 7da ffffffff 00000000
rand_mepc  rnd 341 fffffffe 00000000
bad_addr   exr 123 00000000 00000001
mvendor_wr exw f11 00000001 00000001
misa_wr    exw 301 ffffffff 00000000
start_cmd  cmd 7dd 00000001 00000001
no_start   cmd 7dc 00000005 00000000
mvu_trap   trp 000 00002468 00000007
cycles     cyc b00 00000019 00000019

//--- flist.f
csr_pkg.sv
csr_op_unit.sv
csr_machine_regs.sv
csr_mvu_regs.sv
csr_file_top.sv
tb_csr_file.sv

//--- tb_csr_file.sv
`timescale 1ns/1ps

module tb_csr_file;
    import csr_pkg::*;

    localparam int unsigned hart_id    = 3;
    localparam int          clk_period = 4;
    localparam xlen_t       boot_addr  = 32'h0000_8000;
    localparam xlen_t       st_mie     = 32'h0000_0008; // mstatus.mie
    localparam xlen_t       st_mpie    = 32'h0000_0080; // mstatus.mpie

    logic       clk;
    logic       rst_n;
    csr_addr_t  csr_addr_i;
    xlen_t      csr_wdata_i;
    csr_op_e    csr_op_i;
    xlen_t      csr_rdata_o;
    exception_t csr_exception_o;
    xlen_t      pc_i;
    xlen_t      cause_i;
    xlen_t      boot_addr_i;
    logic       mvu_irq_i;
    logic       enable_cycle_count_i;
    irq_evt_t   csr_irq_evt_o;
    mvu_cfg_t   mvu_cfg_o;
    logic       mvu_start_o;

    string     rec_name [$];
    string     rec_kind [$];
    csr_addr_t rec_addr [$];
    xlen_t     rec_wdata [$];
    xlen_t     rec_exp [$];
    logic      loaded    = 1'b0;
    xlen_t     rng_state = 32'd56;
    xlen_t     cfg_model [mvu_num_regs]; // expected MVU words from wbaseaddr up

    csr_file_top #(.HART_ID(hart_id)) i_dut (.*);

    // ======================================================================
    // checking
    // ======================================================================
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp)
            stop_on_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_failure($sformatf("error %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_exc(input string name, input exception_t exp, input exception_t act);
        if (act !== exp)
            stop_on_failure($sformatf(
                "error %s: expected valid %b cause %h, actual valid %b cause %h",
                name, exp.valid, exp.cause, act.valid, act.cause));
    endtask

    task automatic check_evt(input string name, input irq_evt_t exp, input irq_evt_t act);
        if (act !== exp)
            stop_on_failure($sformatf("error %s: expected %b/%0d/%h, actual %b/%0d/%h", name,
                exp.valid, exp.hart_id, exp.target, act.valid, act.hart_id, act.target));
    endtask

    task automatic check_cfg(input string name, input mvu_cfg_t exp, input mvu_cfg_t act);
        if (act !== exp)
            stop_on_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    function automatic xlen_t next_rand();
        rng_state = rng_state ^ (rng_state << 13); // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic is_mvu(input csr_addr_t a);
        return (a >= csr_mvu_wbaseaddr) && (a <= csr_mvu_command);
    endfunction

    // field layout follows the address map with one word per dimension
    function automatic mvu_cfg_t pack_cfg();
        mvu_cfg_t c;
        c.wbase = cfg_model[0];
        c.ibase = cfg_model[1];
        c.obase = cfg_model[2];
        for (int d = 0; d < 4; d++) begin
            c.wstride[d] = cfg_model[3 + d];
            c.istride[d] = cfg_model[7 + d];
            c.ostride[d] = cfg_model[11 + d];
            c.wlength[d] = cfg_model[15 + d];
            c.ilength[d] = cfg_model[19 + d];
            c.olength[d] = cfg_model[23 + d];
        end
        c.precision = cfg_model[27];
        c.quant     = cfg_model[28];
        c.command   = cfg_model[29];
        return c;
    endfunction

    // ======================================================================
    // access sequences
    // ======================================================================
    task automatic access(input csr_op_e op, input csr_addr_t addr, input xlen_t wdata);
        @(posedge clk);
        #1;
        csr_op_i    = op;
        csr_addr_i  = addr;
        csr_wdata_i = wdata;
        @(negedge clk); // outputs settled here
    endtask

    task automatic read_check(input string name, input csr_addr_t addr, input xlen_t exp);
        access(csr_op_set, addr, '0); // set with zero mask is a plain read
        check_exc(name, '0, csr_exception_o);
        check_word(name, exp, csr_rdata_o);
    endtask

    task automatic write_check(input string name, input csr_op_e op, input csr_addr_t addr,
                               input xlen_t wdata, input xlen_t exp);
        access(op, addr, wdata);
        check_exc(name, '0, csr_exception_o);
        read_check(name, addr, exp);
        if (is_mvu(addr)) begin
            cfg_model[int'(addr) - int'(csr_mvu_wbaseaddr)] = exp;
            check_cfg(name, pack_cfg(), mvu_cfg_o);
        end
    endtask

    task automatic run_random(input string name, input csr_addr_t addr, input xlen_t mask);
        xlen_t r;
        xlen_t model;
        r     = next_rand();
        model = r & mask;
        write_check({name, "_rw"}, csr_op_rw, addr, r, model);
        r     = next_rand();
        model = (model | r) & mask;
        write_check({name, "_set"}, csr_op_set, addr, r, model);
        r     = next_rand();
        model = model & ~r & mask;
        write_check({name, "_clr"}, csr_op_clear, addr, r, model);
    endtask

    task automatic run_exception(input string name, input csr_op_e op, input csr_addr_t addr,
                                 input xlen_t wdata, input logic flag);
        exception_t e;
        e.valid = flag;
        e.cause = flag ? illegal_instr : '0;
        access(op, addr, wdata);
        check_exc(name, e, csr_exception_o);
    endtask

    task automatic run_start(input string name, input csr_addr_t addr, input xlen_t wdata,
                             input logic exp);
        access(csr_op_rw, addr, wdata);
        check_bit(name, 1'b0, mvu_start_o);
        access(csr_op_none, '0, '0);
        check_bit(name, exp, mvu_start_o);   // the cycle right after the write
        cfg_model[int'(addr) - int'(csr_mvu_wbaseaddr)] = wdata;
        check_cfg(name, pack_cfg(), mvu_cfg_o);
        access(csr_op_none, '0, '0);
        check_bit(name, 1'b0, mvu_start_o);
    endtask

    task automatic run_trap(input string name, input xlen_t pc, input xlen_t cause);
        irq_evt_t evt;
        int       waited;
        write_check({name, "_mie"}, csr_op_set, csr_mie, 32'h1 << irq_mvu, 32'h1 << irq_mvu);
        write_check({name, "_mstatus"}, csr_op_set, csr_mstatus, st_mie, st_mie);
        @(posedge clk);
        #1;
        csr_op_i  = csr_op_none;
        pc_i      = pc;
        cause_i   = cause;
        mvu_irq_i = 1'b1;
        @(posedge clk);
        #1;
        mvu_irq_i = 1'b0;
        waited    = 0;
        @(negedge clk);
        while (!csr_irq_evt_o.valid) begin
            if (waited == 8)
                stop_on_failure("no trap event arrived after the MVU interrupt");
            @(negedge clk);
            waited++;
        end
        evt.valid   = 1'b1;
        evt.hart_id = 8'(hart_id);
        evt.target  = boot_addr;              // mtvec was never written
        check_evt({name, "_entry"}, evt, csr_irq_evt_o);
        read_check({name, "_mcause"}, csr_mcause, 32'h8000_0000 | (cause & 32'h0000_001f));
        read_check({name, "_mepc"}, csr_mepc, pc);
        read_check({name, "_mstatus"}, csr_mstatus, st_mpie);
        write_check({name, "_mip"}, csr_op_clear, csr_mip, 32'h1 << irq_mvu, '0);
        access(csr_op_mret, '0, '0);
        evt.target = pc;
        check_evt({name, "_mret"}, evt, csr_irq_evt_o);
        read_check({name, "_restore"}, csr_mstatus, st_mpie | st_mie);
        write_check({name, "_quiet"}, csr_op_clear, csr_mstatus, st_mie, st_mpie);
    endtask

    task automatic run_cycles(input string name, input int n, input xlen_t exp);
        write_check({name, "_lo"}, csr_op_rw, csr_mcycle, '0, '0);
        write_check({name, "_hi"}, csr_op_rw, csr_mcycleh, '0, '0);
        @(posedge clk);
        #1;
        enable_cycle_count_i = 1'b1;
        repeat (n) @(posedge clk);  // n edges see the enable
        #1;
        enable_cycle_count_i = 1'b0;
        read_check(name, csr_mcycle, exp);
        read_check({name, "_upper"}, csr_mcycleh, '0);
    endtask

    task automatic run_record(input int i);
        string     k;
        csr_addr_t a;
        xlen_t     w;
        xlen_t     e;
        k = rec_kind[i];
        a = rec_addr[i];
        w = rec_wdata[i];
        e = rec_exp[i];
        if (k == "rd")       read_check(rec_name[i], a, e);
        else if (k == "rw")  write_check(rec_name[i], csr_op_rw, a, w, e);
        else if (k == "set") write_check(rec_name[i], csr_op_set, a, w, e);
        else if (k == "clr") write_check(rec_name[i], csr_op_clear, a, w, e);
        else if (k == "rnd") run_random(rec_name[i], a, w);
        else if (k == "exr") run_exception(rec_name[i], csr_op_set, a, '0, e[0]);
        else if (k == "exw") run_exception(rec_name[i], csr_op_rw, a, w, e[0]);
        else if (k == "cmd") run_start(rec_name[i], a, w, e[0]);
        else if (k == "trp") run_trap(rec_name[i], w, e);
        else if (k == "cyc") run_cycles(rec_name[i], int'(w), e);
        else stop_on_failure($sformatf("unknown record kind %s in the stimulus file", k));
    endtask

    task automatic load_records();
        int        fd;
        int        n;
        string     line;
        string     name;
        string     kind;
        csr_addr_t addr;
        xlen_t     wdata;
        xlen_t     exp;
        fd = $fopen("csr_stim.txt", "r");
        if (fd == 0)
            stop_on_failure("could not open the stimulus file csr_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h", name, kind, addr, wdata, exp);
                if (n == 5) begin
                    rec_name.push_back(name);
                    rec_kind.push_back(kind);
                    rec_addr.push_back(addr);
                    rec_wdata.push_back(wdata);
                    rec_exp.push_back(exp);
                end
            end
        end
        $fclose(fd);
    endtask

    // ======================================================================
    // clock, main sequence, watchdog
    // ======================================================================
    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        rst_n                = 1'b0;
        csr_addr_i           = '0;
        csr_wdata_i          = '0;
        csr_op_i             = csr_op_none;
        pc_i                 = '0;
        cause_i              = '0;
        mvu_irq_i            = 1'b0;
        enable_cycle_count_i = 1'b0;
        boot_addr_i          = boot_addr;
        for (int i = 0; i < mvu_num_regs; i++) begin
            cfg_model[i] = '0;
        end
        load_records();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < rec_name.size(); i++) begin
            run_record(i);
        end
        $display("Everything OK");
        $finish;
    end

    initial begin
        wait (loaded);
        #((rec_name.size() * 20 + 200) * clk_period);
        stop_on_failure("timeout: the records did not complete in the expected time");
    end

endmodule

//--- csr_file_top.sv
`timescale 1ns/1ps

module csr_file_top #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    // access port
    input  csr_pkg::csr_addr_t  csr_addr_i,
    input  csr_pkg::xlen_t      csr_wdata_i,
    input  csr_pkg::csr_op_e    csr_op_i,
    output csr_pkg::xlen_t      csr_rdata_o,
    output csr_pkg::exception_t csr_exception_o,
    // core side
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      cause_i,
    input  logic                enable_cycle_count_i,
    input  csr_pkg::xlen_t      boot_addr_i,
    output csr_pkg::irq_evt_t   csr_irq_evt_o,
    // MVU side
    input  logic                mvu_irq_i,
    output csr_pkg::mvu_cfg_t   mvu_cfg_o,
    output logic                mvu_start_o
);
    import csr_pkg::*;

    csr_req_t req;
    xlen_t    rdata_mach, rdata_mvu;
    logic     hit_mach, hit_mvu;
    logic     illegal;

    csr_op_unit i_op (
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_op_i    (csr_op_i),
        .old_rdata_i (csr_rdata_o),  // old value for set and clear
        .req_o       (req)
    );

    csr_machine_regs #(
        .HART_ID (HART_ID)
    ) i_mach (
        .clk                  (clk),
        .rst_n                (rst_n),
        .req_i                (req),
        .pc_i                 (pc_i),
        .cause_i              (cause_i),
        .mvu_irq_i            (mvu_irq_i),
        .enable_cycle_count_i (enable_cycle_count_i),
        .boot_addr_i          (boot_addr_i),
        .rdata_o              (rdata_mach),
        .hit_o                (hit_mach),
        .irq_evt_o            (csr_irq_evt_o)
    );

    csr_mvu_regs i_mvu (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req),
        .rdata_o (rdata_mvu),
        .hit_o   (hit_mvu),
        .cfg_o   (mvu_cfg_o),
        .start_o (mvu_start_o)
    );

    // units return zero outside their own addresses
    assign csr_rdata_o = rdata_mach | rdata_mvu;

    // unknown address or a write to a read-only register
    assign illegal               = (req.re || req.we) && !(hit_mach || hit_mvu);
    assign csr_exception_o.valid = illegal;
    assign csr_exception_o.cause = illegal ? illegal_instr : '0;

endmodule

//--- csr_mvu_regs.sv
`timescale 1ns/1ps

module csr_mvu_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_req_t req_i,
    output csr_pkg::xlen_t    rdata_o,
    output logic              hit_o,
    output csr_pkg::mvu_cfg_t cfg_o,
    output logic              start_o
);
    import csr_pkg::*;

    localparam int idx_w = $clog2(mvu_num_regs);

    // word offsets inside the config block
    localparam int base_ofs    = 0;
    localparam int wstride_ofs = int'(csr_mvu_wstride_0) - int'(csr_mvu_wbaseaddr);
    localparam int istride_ofs = int'(csr_mvu_istride_0) - int'(csr_mvu_wbaseaddr);
    localparam int ostride_ofs = int'(csr_mvu_ostride_0) - int'(csr_mvu_wbaseaddr);
    localparam int wlength_ofs = int'(csr_mvu_wlength_0) - int'(csr_mvu_wbaseaddr);
    localparam int ilength_ofs = int'(csr_mvu_ilength_0) - int'(csr_mvu_wbaseaddr);
    localparam int olength_ofs = int'(csr_mvu_olength_0) - int'(csr_mvu_wbaseaddr);
    localparam int prec_ofs    = int'(csr_mvu_precision) - int'(csr_mvu_wbaseaddr);
    localparam int quant_ofs   = int'(csr_mvu_quant)     - int'(csr_mvu_wbaseaddr);
    localparam int cmd_ofs     = int'(csr_mvu_command)   - int'(csr_mvu_wbaseaddr);

    xlen_t            cfg_q [mvu_num_regs];
    csr_addr_t        ofs;
    logic [idx_w-1:0] idx;
    logic             in_range;
    logic             cmd_we;

    // addresses below the block wrap to large offsets
    assign ofs      = req_i.addr - csr_addr_t'(csr_mvu_wbaseaddr);
    assign in_range = (ofs < csr_addr_t'(mvu_num_regs));
    assign idx      = ofs[idx_w-1:0];
    assign cmd_we   = req_i.we && (req_i.addr == csr_mvu_command);

    assign hit_o   = in_range;
    assign rdata_o = in_range ? cfg_q[idx] : '0;

    // ======================================================================
    // config words
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mvu_num_regs; i++) begin
                cfg_q[i] <= '0;
            end
            start_o <= 1'b0;
        end else begin
            if (req_i.we && in_range) begin
                cfg_q[idx] <= req_i.wdata;
            end
            start_o <= cmd_we; // high for the one cycle after a command write
        end
    end

    // unpack the flat word array into the config bundle
    always_comb begin
        cfg_o.wbase     = cfg_q[base_ofs];
        cfg_o.ibase     = cfg_q[base_ofs + 1];
        cfg_o.obase     = cfg_q[base_ofs + 2];
        for (int d = 0; d < 4; d++) begin
            cfg_o.wstride[d] = cfg_q[wstride_ofs + d];
            cfg_o.istride[d] = cfg_q[istride_ofs + d];
            cfg_o.ostride[d] = cfg_q[ostride_ofs + d];
            cfg_o.wlength[d] = cfg_q[wlength_ofs + d];
            cfg_o.ilength[d] = cfg_q[ilength_ofs + d];
            cfg_o.olength[d] = cfg_q[olength_ofs + d];
        end
        cfg_o.precision = cfg_q[prec_ofs];
        cfg_o.quant     = cfg_q[quant_ofs];
        cfg_o.command   = cfg_q[cmd_ofs];
    end

    // the start pulse and the command word come from the same write
    start_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        start_o |-> $past(req_i.we && in_range && (idx == idx_w'(cmd_ofs)))
                    && (cfg_o.command == $past(req_i.wdata)))
        else $error("mvu start without a command write");

endmodule

//--- csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs #(
    parameter int unsigned HART_ID = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_req_t req_i,
    input  csr_pkg::xlen_t    pc_i,
    input  csr_pkg::xlen_t    cause_i,
    input  logic              mvu_irq_i,
    input  logic              enable_cycle_count_i,
    input  csr_pkg::xlen_t    boot_addr_i,
    output csr_pkg::xlen_t    rdata_o,
    output logic              hit_o,
    output csr_pkg::irq_evt_t irq_evt_o
);
    import csr_pkg::*;

    mstatus_t    mstatus_q, mstatus_d;
    xlen_t       mie_q, mie_d;
    xlen_t       mip_q, mip_d;
    xlen_t       mtvec_q, mtvec_d;
    xlen_t       mepc_q, mepc_d;
    xlen_t       mcause_q, mcause_d;
    logic [63:0] mcycle_q, mcycle_d;
    logic        mtvec_load_q;   // high until the first edge after reset
    logic        mip_we;
    logic        trap;

    assign mip_we = req_i.we && (req_i.addr == csr_mip);
    assign trap   = mstatus_q.mie && mip_q[irq_mvu] && mie_q[irq_mvu];

    // trap has priority over a return in the same cycle
    assign irq_evt_o.valid   = trap || req_i.mret;
    assign irq_evt_o.hart_id = 8'(HART_ID);
    assign irq_evt_o.target  = trap ? mtvec_q : mepc_q;

    // ======================================================================
    // read mux and hit
    // ======================================================================
    always_comb begin
        rdata_o = '0;
        hit_o   = 1'b1;
        case (req_i.addr)
            csr_mvendorid, csr_mimpid: hit_o = !req_i.we; // both read zero
            csr_marchid: begin
                rdata_o = marchid_val;
                hit_o   = !req_i.we;
            end
            csr_mhartid: begin
                rdata_o = xlen_t'(HART_ID);
                hit_o   = !req_i.we;
            end
            csr_misa:    rdata_o = misa_val;   // writes accepted and dropped
            csr_mstatus: rdata_o = xlen_t'(mstatus_q);
            csr_mie:     rdata_o = mie_q;
            csr_mtvec:   rdata_o = mtvec_q;
            csr_mepc:    rdata_o = mepc_q;
            csr_mcause:  rdata_o = mcause_q;
            csr_mip:     rdata_o = mip_q;
            csr_mcycle:  rdata_o = mcycle_q[31:0];
            csr_mcycleh: rdata_o = mcycle_q[63:32];
            default:     hit_o   = 1'b0;
        endcase
    end

    // ======================================================================
    // next state
    // ======================================================================
    always_comb begin
        mstatus_d = mstatus_q;
        mie_d     = mie_q;
        mip_d     = mip_q;
        mtvec_d   = mtvec_load_q ? boot_addr_i : mtvec_q;
        mepc_d    = mepc_q;
        mcause_d  = mcause_q;
        mcycle_d  = enable_cycle_count_i ? mcycle_q + 64'd1 : mcycle_q;

        if (req_i.we) begin
            case (req_i.addr)
                csr_mstatus: begin
                    mstatus_d      = mstatus_t'(req_i.wdata);
                    mstatus_d.sd   = 1'b0;  // no extension state
                    mstatus_d.xs   = 2'b0;
                    mstatus_d.fs   = 2'b0;
                    mstatus_d.upie = 1'b0;  // no user mode
                    mstatus_d.uie  = 1'b0;
                end
                csr_mie:     mie_d    = req_i.wdata & irq_mask;
                csr_mip:     mip_d    = req_i.wdata & irq_mask;
                csr_mtvec:   mtvec_d  = req_i.wdata;
                csr_mepc:    mepc_d   = {req_i.wdata[31:1], 1'b0};
                csr_mcause:  mcause_d = req_i.wdata;
                csr_mcycle:  mcycle_d[31:0]  = req_i.wdata;
                csr_mcycleh: mcycle_d[63:32] = req_i.wdata;
                default: ;
            endcase
        end

        // mvu pending sticks until software clears it through mip
        if (!mip_we) begin
            mip_d[irq_mvu] = mip_q[irq_mvu] | mvu_irq_i;
        end

        if (trap) begin
            mcause_d       = {1'b1, 26'b0, cause_i[4:0]};
            mepc_d         = pc_i;
            mstatus_d.mpie = mstatus_q.mie;
            mstatus_d.mie  = 1'b0;
        end else if (req_i.mret) begin
            mstatus_d.mie  = mstatus_q.mpie;
            mstatus_d.mpie = 1'b1;
        end
    end

    // ======================================================================
    // registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q    <= '0;
            mie_q        <= '0;
            mip_q        <= '0;
            mtvec_q      <= '0;
            mepc_q       <= '0;
            mcause_q     <= '0;
            mcycle_q     <= '0;
            mtvec_load_q <= 1'b1;
        end else begin
            mstatus_q    <= mstatus_d;
            mie_q        <= mie_d;
            mip_q        <= mip_d;
            mtvec_q      <= mtvec_d;
            mepc_q       <= mepc_d;
            mcause_q     <= mcause_d;
            mcycle_q     <= mcycle_d;
            mtvec_load_q <= 1'b0;
        end
    end

    // enables exist only for the four supported sources
    mie_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (mie_q & ~irq_mask) == '0)
        else $error("mie holds unsupported interrupt bits");

endmodule

//--- csr_op_unit.sv
`timescale 1ns/1ps

module csr_op_unit (
    input  csr_pkg::csr_addr_t csr_addr_i,
    input  csr_pkg::xlen_t     csr_wdata_i,
    input  csr_pkg::csr_op_e   csr_op_i,
    input  csr_pkg::xlen_t     old_rdata_i, // merged read data of both register units
    output csr_pkg::csr_req_t  req_o
);
    import csr_pkg::*;

    logic wdata_nz;

    assign wdata_nz = |csr_wdata_i;

    // ======================================================================
    // op decode
    // ======================================================================
    always_comb begin
        req_o       = '0;
        req_o.addr  = csr_addr_i;
        req_o.wdata = csr_wdata_i;

        case (csr_op_i)
            csr_op_rw: begin
                req_o.re = 1'b1;
                req_o.we = 1'b1;
            end
            // set and clear with a zero mask are plain reads,
            // so read-only registers can be read this way
            csr_op_set: begin
                req_o.re    = 1'b1;
                req_o.we    = wdata_nz;
                req_o.wdata = old_rdata_i | csr_wdata_i;
            end
            csr_op_clear: begin
                req_o.re    = 1'b1;
                req_o.we    = wdata_nz;
                req_o.wdata = old_rdata_i & ~csr_wdata_i;
            end
            csr_op_mret: begin
                req_o.mret = 1'b1;   // no register side effects
            end
            csr_op_none: ;
            default: ;
        endcase
    end

endmodule

//--- csr_pkg.sv
package csr_pkg;

    // ======================================================================
    // basic word types
    // ======================================================================
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // implemented CSR addresses
    typedef enum csr_addr_t {
        // identification, read only
        csr_mvendorid     = 12'hF11,
        csr_marchid       = 12'hF12,
        csr_mimpid        = 12'hF13,
        csr_mhartid       = 12'hF14,
        // machine trap setup and handling
        csr_mstatus       = 12'h300,
        csr_misa          = 12'h301,
        csr_mie           = 12'h304,
        csr_mtvec         = 12'h305,
        csr_mepc          = 12'h341,
        csr_mcause        = 12'h342,
        csr_mip           = 12'h344,
        // counters
        csr_mcycle        = 12'hB00,
        csr_mcycleh       = 12'hB80,
        // MVU config, one contiguous block in the custom machine range
        csr_mvu_wbaseaddr = 12'h7C0,
        csr_mvu_ibaseaddr = 12'h7C1,
        csr_mvu_obaseaddr = 12'h7C2,
        csr_mvu_wstride_0 = 12'h7C3,
        csr_mvu_wstride_1 = 12'h7C4,
        csr_mvu_wstride_2 = 12'h7C5,
        csr_mvu_wstride_3 = 12'h7C6,
        csr_mvu_istride_0 = 12'h7C7,
        csr_mvu_istride_1 = 12'h7C8,
        csr_mvu_istride_2 = 12'h7C9,
        csr_mvu_istride_3 = 12'h7CA,
        csr_mvu_ostride_0 = 12'h7CB,
        csr_mvu_ostride_1 = 12'h7CC,
        csr_mvu_ostride_2 = 12'h7CD,
        csr_mvu_ostride_3 = 12'h7CE,
        csr_mvu_wlength_0 = 12'h7CF,
        csr_mvu_wlength_1 = 12'h7D0,
        csr_mvu_wlength_2 = 12'h7D1,
        csr_mvu_wlength_3 = 12'h7D2,
        csr_mvu_ilength_0 = 12'h7D3,
        csr_mvu_ilength_1 = 12'h7D4,
        csr_mvu_ilength_2 = 12'h7D5,
        csr_mvu_ilength_3 = 12'h7D6,
        csr_mvu_olength_0 = 12'h7D7,
        csr_mvu_olength_1 = 12'h7D8,
        csr_mvu_olength_2 = 12'h7D9,
        csr_mvu_olength_3 = 12'h7DA,
        csr_mvu_precision = 12'h7DB,
        csr_mvu_quant     = 12'h7DC,
        csr_mvu_command   = 12'h7DD
    } csr_addr_e;

    localparam int mvu_num_regs = 30; // words from wbaseaddr up to command

    typedef enum logic [2:0] {
        csr_op_none  = 3'd0,
        csr_op_rw    = 3'd1,
        csr_op_set   = 3'd2,
        csr_op_clear = 3'd3,
        csr_op_mret  = 3'd4
    } csr_op_e;

    // ======================================================================
    // machine registers
    // ======================================================================
    typedef struct packed {
        logic        sd;
        logic [13:0] wpri3;
        logic [1:0]  xs;
        logic [1:0]  fs;
        logic [4:0]  wpri2;  // mpp and spp live here, machine mode only
        logic        mpie;
        logic [1:0]  wpri1;
        logic        upie;
        logic        mie;
        logic [1:0]  wpri0;
        logic        uie;
    } mstatus_t;

    // interrupt bit positions in mie and mip
    localparam int irq_m_soft  = 3;
    localparam int irq_m_timer = 7;
    localparam int irq_m_ext   = 11;
    localparam int irq_mvu     = 16; // first platform bit

    localparam xlen_t irq_mask = (xlen_t'(1) << irq_m_soft) | (xlen_t'(1) << irq_m_timer)
                               | (xlen_t'(1) << irq_m_ext)  | (xlen_t'(1) << irq_mvu);

    localparam xlen_t marchid_val = 32'h0000_0021;
    localparam xlen_t misa_val    = 32'h4000_0100; // rv32, base integer only

    // ======================================================================
    // port bundles
    // ======================================================================
    typedef struct packed {
        csr_addr_t addr;
        xlen_t     wdata;
        logic      we;
        logic      re;
        logic      mret;
    } csr_req_t;

    typedef struct packed {
        logic  valid;
        xlen_t cause;
    } exception_t;

    localparam xlen_t illegal_instr = 32'd2;

    typedef struct packed {
        logic       valid;
        logic [7:0] hart_id;
        xlen_t      target; // mtvec on trap, mepc on mret
    } irq_evt_t;

    typedef struct packed {
        xlen_t       wbase;
        xlen_t       ibase;
        xlen_t       obase;
        xlen_t [3:0] wstride;
        xlen_t [3:0] istride;
        xlen_t [3:0] ostride;
        xlen_t [3:0] wlength;
        xlen_t [3:0] ilength;
        xlen_t [3:0] olength;
        xlen_t       precision;
        xlen_t       quant;
        xlen_t       command;
    } mvu_cfg_t;

endpackage
